//--- src/pad_pkg.sv
/*
 * Shared definitions for the console pad port logic.
 * Blocks that need the pad word layout, the host joystick word
 * or the multitap constants import this package by wildcard
 * in their module header.
 */

package pad_pkg;

	// ====================
	// Widths and counts
	// ====================

	// Host joystick bits in use: directions, four buttons, four extras
	localparam int JOY_WIDTH = 12;

	// Multitap ports that can carry a pad
	localparam int PORT_COUNT = 5;

	// Port index runs 0 to 7
	// Indexes at or past PORT_COUNT read as empty
	localparam int PORT_IDX_WIDTH = 3;

	// One mouse motion axis
	localparam int MOTION_WIDTH = 8;

	// No pad fitted, low nibbles released and top nibble low
	localparam logic [15:0] EMPTY_PORT_WORD = 16'h0FFF;

	// ====================
	// Word types
	// ====================

	// Host joystick word, active high
	//   [3:0]  right, left, down, up
	//   [7:4]  I, II, select, run
	//   [11:8] III, IV, V, VI
	typedef logic [JOY_WIDTH-1:0] joy_word_t;

	// Pad word as the console sees it
	// Built through the button fields, read out one nibble at a time.
	// Nibble number is 2 * bank + select:
	//   0 keys, 1 dirs, 2 extra, 3 id
	typedef union packed {
		struct packed {
			logic [3:0] id;     // id nibble, zero when built
			logic [3:0] extra;  // VI, V, IV, III
			logic [3:0] dirs;   // left, down, right, up
			logic [3:0] keys;   // run, select, II, I
		} f;
		logic [3:0][3:0] nib;
	} pad_word_t;

endpackage

//--- src/port_sequencer.sv
/*
 * Stage 1 of the pad port pipeline.
 * Samples the console select and clear lines, finds their rising
 * edges and runs the multitap port index and six-button bank.
 * Its registered outputs feed the word mux on the next clock.
 */

module port_sequencer import pad_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,

	// Configuration levels
	input  logic                      turbotap,
	input  logic                      buttons6,

	// Console pad port lines
	input  logic                      pad_sel,
	input  logic                      pad_clr,

	// Registered line levels
	output logic                      sel_q,
	output logic                      clr_q,

	// Clear rising edge, one cycle
	output logic                      clr_rise,

	// Port and bank for the word mux
	output logic [PORT_IDX_WIDTH-1:0] port_idx,
	output logic                      bank_hi
);

	logic                      sel_rise;
	logic [PORT_IDX_WIDTH-1:0] port_idx_next;
	logic                      bank_hi_next;

	// ====================
	// Edge detection
	// ====================

	// Compared with the levels seen at the previous clock
	assign clr_rise = pad_clr & ~clr_q;
	assign sel_rise = pad_sel & ~sel_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_q <= 1'b0;
			clr_q <= 1'b0;
		end else begin
			sel_q <= pad_sel;
			clr_q <= pad_clr;
		end
	end

	// ====================
	// Port and bank
	// ====================

	// Clear parks the scan on port 0 for as long as it is held
	// Each select rise moves to the next multitap port, wrapping at 8
	always_comb begin
		port_idx_next = port_idx;
		if (pad_clr) begin
			port_idx_next = '0;
		end else if (sel_rise && turbotap) begin
			port_idx_next = port_idx + PORT_IDX_WIDTH'(1);
		end
	end

	// Six-button pads flip bank on every clear
	// Two-button mode keeps the low bank
	always_comb begin
		bank_hi_next = bank_hi;
		if (clr_rise) begin
			bank_hi_next = buttons6 ? ~bank_hi : 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_idx <= '0;
			bank_hi  <= 1'b0;
		end else begin
			port_idx <= port_idx_next;
			bank_hi  <= bank_hi_next;
		end
	end

endmodule

//--- src/mouse_tracker.sv
/*
 * Mouse side of stage 1.
 * Holds the latest motion, snapshots it once per four-clear cycle
 * and presents the motion nibble for the current phase.
 * An idle counter parks the phase so the next clear starts over.
 */

module mouse_tracker import pad_pkg::*; #(
	parameter int MOUSE_TIMEOUT_BITS = 15
) (
	input  logic                    clk_sys,
	input  logic                    reset,

	// From the port sequencer and the console
	input  logic                    clr_rise,
	input  logic                    pad_clr,

	// Host mouse motion, valid with the strobe
	input  logic                    mouse_strobe,
	input  logic [MOTION_WIDTH-1:0] mouse_x,
	input  logic [MOTION_WIDTH-1:0] mouse_y,

	// High nibble of the mouse byte
	output logic [3:0]              mouse_nibble
);

	logic [MOTION_WIDTH-1:0]       acc_x;
	logic [MOTION_WIDTH-1:0]       acc_y;
	logic [MOTION_WIDTH-1:0]       snap_x;
	logic [MOTION_WIDTH-1:0]       snap_y;
	logic [1:0]                    phase;
	logic [MOUSE_TIMEOUT_BITS-1:0] idle_cnt;
	logic                          idle_full;
	logic                          phase_wrap;

	assign idle_full  = &idle_cnt;
	assign phase_wrap = clr_rise && (phase == 2'd3);

	// ====================
	// Idle timeout
	// ====================

	// Restarts whenever the console holds clear, saturates otherwise
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idle_cnt <= '0;
		end else if (pad_clr) begin
			idle_cnt <= '0;
		end else if (!idle_full) begin
			idle_cnt <= idle_cnt + MOUSE_TIMEOUT_BITS'(1);
		end
	end

	// Clear edge wins over the timeout park
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase <= 2'd0;
		end else if (clr_rise) begin
			phase <= phase + 2'd1;
		end else if (idle_full) begin
			phase <= 2'd3;
		end
	end

	// ====================
	// Motion capture
	// ====================

	// X is reported with the opposite sign
	// A strobe on the wrap cycle survives the clear
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc_x  <= '0;
			acc_y  <= '0;
			snap_x <= '0;
			snap_y <= '0;
		end else begin
			if (phase_wrap) begin
				snap_x <= acc_x;
				snap_y <= acc_y;
				acc_x  <= '0;
				acc_y  <= '0;
			end
			if (mouse_strobe) begin
				acc_x <= '0 - mouse_x;
				acc_y <= mouse_y;
			end
		end
	end

	// X high, X low, Y high, Y low
	always_comb begin
		case (phase)
			2'd0:    mouse_nibble = snap_x[MOTION_WIDTH-1 -: 4];
			2'd1:    mouse_nibble = snap_x[3:0];
			2'd2:    mouse_nibble = snap_y[MOTION_WIDTH-1 -: 4];
			default: mouse_nibble = snap_y[3:0];
		endcase
	end

endmodule

//--- src/pad_word_mux.sv
/*
 * Stages 2 and 3 of the pad port pipeline.
 * Builds the active-low pad word for the selected multitap port,
 * or the mouse byte pair on port 0, then latches one nibble of it
 * onto the console read lines.
 */

module pad_word_mux import pad_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,

	// Configuration levels
	input  logic                      joy_swap,
	input  logic                      mouse_en,

	// Stage 1 state
	input  logic                      sel_q,
	input  logic                      clr_q,
	input  logic                      bank_hi,
	input  logic [PORT_IDX_WIDTH-1:0] port_idx,

	// Host joysticks, active high
	input  joy_word_t                 joy_a,
	input  joy_word_t                 joy_b,
	input  joy_word_t                 joy_2,
	input  joy_word_t                 joy_3,
	input  joy_word_t                 joy_4,

	// Mouse buttons (left, right) and motion nibble
	input  logic [1:0]                mouse_btn,
	input  logic [3:0]                mouse_nibble,

	// Console read lines, active low
	output logic [3:0]                pad_nibble
);

	joy_word_t  joy_0;
	joy_word_t  joy_1;
	joy_word_t  port_joy [PORT_COUNT];
	logic [3:0] mouse_keys;
	logic [7:0] mouse_byte;
	pad_word_t  mouse_word;
	pad_word_t  sel_word;

	// Host joystick bits rearranged into pad fields, still active high
	function automatic pad_word_t build_fields(input joy_word_t joy);
		pad_word_t w;
		w.f.id    = 4'h0;
		w.f.extra = joy[11:8];
		w.f.dirs  = {joy[1], joy[2], joy[0], joy[3]};
		w.f.keys  = joy[7:4];
		return w;
	endfunction

	// ====================
	// Word selection
	// ====================

	assign joy_0 = joy_swap ? joy_b : joy_a;
	assign joy_1 = joy_swap ? joy_a : joy_b;

	always_comb begin
		port_joy[0] = joy_0;
		port_joy[1] = joy_1;
		port_joy[2] = joy_2;
		port_joy[3] = joy_3;
		port_joy[4] = joy_4;
	end

	// Mouse keeps run and select of the first pad
	assign mouse_keys = {joy_0[7], joy_0[6], mouse_btn[0], mouse_btn[1]};

	assign mouse_byte = {mouse_nibble, ~mouse_keys};
	assign mouse_word = {mouse_byte, mouse_byte};

	always_comb begin
		if (port_idx == '0 && mouse_en) begin
			sel_word = mouse_word;
		end else if (port_idx < PORT_IDX_WIDTH'(PORT_COUNT)) begin
			sel_word = ~build_fields(port_joy[port_idx]);
		end else begin
			sel_word = EMPTY_PORT_WORD;
		end
	end

	// ====================
	// Nibble latch
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pad_nibble <= 4'h0;
		end else if (clr_q) begin
			pad_nibble <= 4'h0;
		end else begin
			pad_nibble <= sel_word.nib[{bank_hi, sel_q}];
		end
	end

endmodule

//--- src/pad_port_top.sv
/*
 * Console controller port top level.
 * Serves up to five pads through a multitap, six-button pads and
 * a mouse on port 0 over the two-line pad port.
 * Reads back two clocks after the console sets its lines.
 */

module pad_port_top import pad_pkg::*; #(
	parameter int MOUSE_TIMEOUT_BITS = 15
) (
	input  logic                    clk_sys,
	input  logic                    reset,

	// Host joysticks, active high
	input  joy_word_t               joy_a,
	input  joy_word_t               joy_b,
	input  joy_word_t               joy_2,
	input  joy_word_t               joy_3,
	input  joy_word_t               joy_4,

	// Host mouse
	input  logic [MOTION_WIDTH-1:0] mouse_x,
	input  logic [MOTION_WIDTH-1:0] mouse_y,
	input  logic                    mouse_strobe,
	input  logic [1:0]              mouse_btn,

	// Configuration levels
	input  logic                    joy_swap,
	input  logic                    turbotap,
	input  logic                    buttons6,
	input  logic                    mouse_en,

	// Console pad port
	input  logic                    pad_sel,
	input  logic                    pad_clr,
	output logic [3:0]              pad_nibble
);

	logic                      sel_q;
	logic                      clr_q;
	logic                      clr_rise;
	logic [PORT_IDX_WIDTH-1:0] port_idx;
	logic                      bank_hi;
	logic [3:0]                mouse_nibble;

	// ====================
	// Stage 1
	// ====================

	port_sequencer port_sequencer_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.turbotap (turbotap),
		.buttons6 (buttons6),
		.pad_sel  (pad_sel),
		.pad_clr  (pad_clr),
		.sel_q    (sel_q),
		.clr_q    (clr_q),
		.clr_rise (clr_rise),
		.port_idx (port_idx),
		.bank_hi  (bank_hi)
	);

	mouse_tracker #(
		.MOUSE_TIMEOUT_BITS (MOUSE_TIMEOUT_BITS)
	) mouse_tracker_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.clr_rise     (clr_rise),
		.pad_clr      (pad_clr),
		.mouse_strobe (mouse_strobe),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_nibble (mouse_nibble)
	);

	// ====================
	// Stages 2 and 3
	// ====================

	pad_word_mux pad_word_mux_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.joy_swap     (joy_swap),
		.mouse_en     (mouse_en),
		.sel_q        (sel_q),
		.clr_q        (clr_q),
		.bank_hi      (bank_hi),
		.port_idx     (port_idx),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.mouse_btn    (mouse_btn),
		.mouse_nibble (mouse_nibble),
		.pad_nibble   (pad_nibble)
	);

endmodule

//--- sim/pad_checker.sv
/*
 * Monitor for the pad port testbench.
 * Keeps its own model of the port pipeline and compares pad_nibble
 * against it on every falling clock edge after reset.
 */

module pad_checker import pad_pkg::*; #(
	parameter int MOUSE_TIMEOUT_BITS = 15
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic [2:0]              test_id,
	input  logic [JOY_WIDTH-1:0]    joy_a, joy_b, joy_2, joy_3, joy_4,
	input  logic [MOTION_WIDTH-1:0] mouse_x, mouse_y,
	input  logic                    mouse_strobe,
	input  logic [1:0]              mouse_btn,
	input  logic                    joy_swap, turbotap, buttons6, mouse_en,
	input  logic                    pad_sel, pad_clr,
	input  logic [3:0]              pad_nibble,
	output int                      check_count,
	output int                      error_count
);

	logic                          sel_q, clr_q, bank;
	logic [2:0]                    port;
	logic [1:0]                    phase;
	logic [MOUSE_TIMEOUT_BITS-1:0] idle;
	logic [7:0]                    acc_x, acc_y, snap_x, snap_y;
	logic [11:0]                   j;
	logic [3:0]                    mnib, exp_nibble;
	logic [7:0]                    mbyte;
	logic [15:0]                   word;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1:    return "single_pad";
			3'd2:    return "multitap_scan";
			3'd3:    return "six_button";
			3'd4:    return "clear_zero";
			3'd5:    return "mouse_seq";
			default: return "startup";
		endcase
	endfunction

	// ====================
	// Expected word
	// ====================

	always_comb begin
		case (port)
			3'd0:    j = joy_swap ? joy_b : joy_a;
			3'd1:    j = joy_swap ? joy_a : joy_b;
			3'd2:    j = joy_2;
			3'd3:    j = joy_3;
			default: j = joy_4;
		endcase
		case (phase)
			2'd0:    mnib = snap_x[7:4];
			2'd1:    mnib = snap_x[3:0];
			2'd2:    mnib = snap_y[7:4];
			default: mnib = snap_y[3:0];
		endcase
		// Run and select stay with the first pad
		mbyte = {mnib, ~{j[7], j[6], mouse_btn[0], mouse_btn[1]}};
		if (port == 3'd0 && mouse_en) begin
			word = {mbyte, mbyte};
		end else if (port > 3'd4) begin
			word = EMPTY_PORT_WORD;
		end else begin
			word = ~{4'h0, j[11:8], j[1], j[2], j[0], j[3], j[7:4]};
		end
	end

	// ====================
	// Model pipeline
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{sel_q, clr_q, bank, port, phase, idle} <= '0;
			{acc_x, acc_y, snap_x, snap_y, exp_nibble} <= '0;
		end else begin
			sel_q <= pad_sel;
			clr_q <= pad_clr;
			if (pad_clr) begin
				port <= 3'd0;
			end else if (pad_sel && !sel_q && turbotap) begin
				port <= port + 3'd1;
			end
			if (pad_clr && !clr_q) begin
				bank  <= buttons6 & ~bank;
				phase <= phase + 2'd1;
				if (phase == 2'd3) begin
					snap_x <= acc_x;
					snap_y <= acc_y;
					acc_x  <= 8'd0;
					acc_y  <= 8'd0;
				end
			end else if (&idle) begin
				phase <= 2'd3;
			end
			if (pad_clr) begin
				idle <= '0;
			end else if (!(&idle)) begin
				idle <= idle + MOUSE_TIMEOUT_BITS'(1);
			end
			if (mouse_strobe) begin
				acc_x <= 8'd0 - mouse_x;
				acc_y <= mouse_y;
			end
			exp_nibble <= clr_q ? 4'h0 : 4'(word >> {bank, sel_q, 2'b00});
		end
	end

	always @(negedge clk_sys) begin
		if (reset) begin
			check_count <= 0;
			error_count <= 0;
		end else begin
			check_count <= check_count + 1;
			if (pad_nibble !== exp_nibble) begin
				error_count <= error_count + 1;
				$display("ERR %s: expected %h, actual %h",
					test_name(test_id), exp_nibble, pad_nibble);
			end
		end
	end

endmodule

//--- sim/tb_pad_port.sv
/*
 * Testbench for the console pad port top level.
 * Runs named test phases of LFSR random stimulus on the pad port,
 * joysticks and mouse. pad_checker compares every read nibble.
 */

module tb_pad_port;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic [11:0] joy_a, joy_b, joy_2, joy_3, joy_4;
	logic [7:0]  mouse_x, mouse_y;
	logic        mouse_strobe;
	logic [1:0]  mouse_btn;
	logic        joy_swap, turbotap, buttons6, mouse_en;
	logic        pad_sel, pad_clr;
	logic [3:0]  pad_nibble;
	logic [2:0]  test_id;
	logic [15:0] lfsr_state;
	int          check_count, error_count, timeouts;

	always #5 clk_sys = ~clk_sys;

	pad_port_top #(.MOUSE_TIMEOUT_BITS(6)) pad_port_top_inst (.*);
	pad_checker #(.MOUSE_TIMEOUT_BITS(6)) pad_checker_inst (.*);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic wait_checks(input int target, input int limit);
		int n;
		n = 0;
		while (check_count < target && n < limit) begin
			@(posedge clk_sys);
			n++;
		end
		if (check_count < target) begin
			timeouts++;
			$display("Timeout: checker reached %0d of %0d compares", check_count, target);
		end
	endtask

	// Lets the previous phase drain, then sets the configuration
	task automatic set_phase(input logic [2:0] id, input logic tt, input logic b6,
			input logic me);
		wait_checks(check_count + 3, 20);
		@(posedge clk_sys);
		test_id  <= id;
		turbotap <= tt;
		buttons6 <= b6;
		mouse_en <= me;
	endtask

	// Clear goes high when clr_bits random bits are all zero
	task automatic drive_random(input int count, input int clr_bits);
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			@(posedge clk_sys);
			take_bits(2, r);
			if (r[1:0] == 2'b00) begin
				take_bits(24, r);
				joy_a <= r[11:0];
				joy_b <= r[23:12];
				take_bits(24, r);
				joy_2 <= r[11:0];
				joy_3 <= r[23:12];
				take_bits(15, r);
				joy_4     <= r[11:0];
				mouse_btn <= r[13:12];
				joy_swap  <= r[14];
			end
			take_bits(18, r);
			mouse_x      <= r[7:0];
			mouse_y      <= r[15:8];
			mouse_strobe <= r[16];
			pad_sel      <= r[17];
			take_bits(clr_bits, r);
			pad_clr <= (r == 32'd0);
		end
	endtask

	// Clear, then ten select rises across the multitap
	task automatic scan_ports(input int rounds);
		// Clear starts low so every round gives one clear edge
		@(posedge clk_sys);
		pad_clr <= 1'b0;
		for (int k = 0; k < rounds; k++) begin
			@(posedge clk_sys);
			pad_clr <= 1'b1;
			pad_sel <= 1'b1;
			@(posedge clk_sys);
			pad_clr <= 1'b0;
			for (int p = 0; p < 20; p++) begin
				@(posedge clk_sys);
				pad_sel <= p[0];
			end
		end
	endtask

	// Holds clear low past the mouse idle limit
	task automatic idle_gap(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk_sys);
			pad_clr      <= 1'b0;
			mouse_strobe <= 1'b0;
		end
	endtask

	initial begin
		lfsr_state = 16'd54221;
		timeouts   = 0;
		reset      = 1'b1;
		test_id    = 3'd0;
		{joy_a, joy_b, joy_2, joy_3, joy_4}         = '0;
		{mouse_x, mouse_y, mouse_strobe, mouse_btn} = '0;
		{joy_swap, turbotap, buttons6, mouse_en}    = '0;
		{pad_sel, pad_clr}                          = '0;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		wait_checks(1, 20);

		set_phase(3'd1, 1'b0, 1'b0, 1'b0);
		drive_random(400, 3);
		set_phase(3'd2, 1'b1, 1'b0, 1'b0);
		scan_ports(12);
		drive_random(300, 4);
		set_phase(3'd3, 1'b1, 1'b1, 1'b0);
		scan_ports(11);
		// Eleven clears leave the high bank for two-button mode to drop
		set_phase(3'd3, 1'b1, 1'b0, 1'b0);
		scan_ports(2);
		set_phase(3'd3, 1'b1, 1'b1, 1'b0);
		drive_random(300, 3);
		set_phase(3'd4, 1'b1, 1'b1, 1'b0);
		drive_random(200, 1);
		set_phase(3'd5, 1'b0, 1'b0, 1'b1);
		drive_random(300, 3);
		idle_gap(80);
		drive_random(100, 3);
		idle_gap(70);
		drive_random(100, 3);
		wait_checks(check_count + 3, 20);

		$display("Compares: %0d, errors: %0d, timeouts: %0d",
			check_count, error_count, timeouts);
		if (error_count == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
src/pad_pkg.sv
src/port_sequencer.sv
src/mouse_tracker.sv
src/pad_word_mux.sv
src/pad_port_top.sv
sim/pad_checker.sv
sim/tb_pad_port.sv

//--- Makefile
# Verilator build and run for the pad port testbench

VERILATOR  ?= verilator
TOP        ?= tb_pad_port
RTL_TOP    ?= pad_port_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
